/* sim.f */
src/icache_pkg.sv
src/refill_if.sv
src/sram_1r1w.sv
src/way_arrays.sv
src/miss_ctrl.sv
src/icache_top.sv
bench/mem_model.sv
bench/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_icache \
    -Mdir obj_dir -o tb_icache \
    && ./obj_dir/tb_icache 2>&1 | tee sim.log
grep -q '^>>> PASS$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* bench/tb_icache.sv */
module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DLY_BITS     = 2;
    localparam int MAX_DLY      = (1 << DLY_BITS) - 1;
    localparam int N_RAND       = 200;
    localparam int N_PKT        = N_RAND + 14;
    // worst case per packet is a miss with every delay at its maximum
    localparam int CYCLE_LIMIT  = N_PKT * (12 + MAX_DLY * 9) + 20;
    localparam int NO_FLUSH     = 0;
    localparam int STAGE_FLUSH  = 1;
    localparam int REFILL_FLUSH = 2;

    logic                    clk;
    logic                    rst_n;
    logic                    flush_i;
    logic                    fetch_valid_i;
    icache_pkg::addr_t       fetch_addr_i;
    icache_pkg::fetch_mask_t fetch_mask_i;
    logic                    fetch_ready_o;
    logic                    dec_valid_o;
    icache_pkg::addr_t       dec_addr_o;
    icache_pkg::fetch_mask_t dec_mask_o;
    icache_pkg::inst_pair_t  dec_insts_o;
    logic                    mem_req_o;
    icache_pkg::addr_t       mem_addr_o;
    icache_pkg::beat_len_t   mem_len_o;
    logic                    mem_ack_i;
    logic                    mem_data_valid_i;
    icache_pkg::inst_t       mem_data_i;

    // cache model, same replacement rule as the design
    bit [19:0]               model_tag [128][2];
    bit                      model_valid [128][2];
    bit                      model_victim [128];

    icache_pkg::addr_t       exp_addr_q [$];
    icache_pkg::fetch_mask_t exp_mask_q [$];
    icache_pkg::inst_pair_t  exp_pair_q [$];
    time                     exp_time_q [$];
    icache_pkg::addr_t       exp_line_q [$];
    int                      req_seen;
    int                      req_expect;
    int                      cycles;

    icache_top dut (.*);

    mem_model #(.DLY_BITS(DLY_BITS)) u_mem (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_req_i        (mem_req_o),
        .mem_addr_i       (mem_addr_o),
        .mem_len_i        (mem_len_o),
        .mem_ack_o        (mem_ack_i),
        .mem_data_valid_o (mem_data_valid_i),
        .mem_data_o       (mem_data_i)
    );

    // lower word at the lower address
    function automatic icache_pkg::inst_pair_t ref_pair(input icache_pkg::addr_t a);
        icache_pkg::addr_t base;
        base = {a[31:3], 3'b000};
        return {u_mem.mem_word(base + 32'd4), u_mem.mem_word(base)};
    endfunction

    function automatic bit model_hit(input icache_pkg::addr_t a);
        logic [6:0] set;
        bit         hit;
        set = a[11:5];
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[set][w] && (model_tag[set][w] == a[31:12])) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic model_fill(input icache_pkg::addr_t a);
        logic [6:0] set;
        set = a[11:5];
        model_valid[set][model_victim[set]] = 1'b1;
        model_tag[set][model_victim[set]]   = a[31:12];
        model_victim[set]                   = !model_victim[set];
    endtask

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pair(input icache_pkg::inst_pair_t got, input icache_pkg::inst_pair_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input icache_pkg::addr_t got, input icache_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mask(input icache_pkg::fetch_mask_t got,
                              input icache_pkg::fetch_mask_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_len(input icache_pkg::beat_len_t got, input icache_pkg::beat_len_t exp,
                             input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_packet(input icache_pkg::addr_t a, input icache_pkg::fetch_mask_t m,
                               input int flush_kind);
        bit  miss;
        time due;
        miss = (m != 2'b00) && !model_hit(a);
        if (flush_kind == REFILL_FLUSH && !miss) begin
            flush_kind = NO_FLUSH;
        end
        fetch_valid_i = 1'b1;
        fetch_addr_i  = a;
        fetch_mask_i  = m;
        @(posedge clk);
        while (!fetch_ready_o) begin
            @(posedge clk);
        end
        // a hit must reach the decoder on the next edge
        due = miss ? 64'd0 : $time + 64'd100;
        if (flush_kind == NO_FLUSH && m != 2'b00) begin
            exp_addr_q.push_back({a[31:3], 3'b000});
            exp_mask_q.push_back(m);
            exp_pair_q.push_back(ref_pair(a));
            exp_time_q.push_back(due);
        end
        if (miss && flush_kind != STAGE_FLUSH) begin
            model_fill(a);
            exp_line_q.push_back({a[31:5], 5'b00000});
            req_expect++;
        end
        @(negedge clk);
        fetch_valid_i = 1'b0;
        if (flush_kind == REFILL_FLUSH) begin
            // refill has left the lookup stage
            @(posedge clk);
            @(negedge clk);
        end
        if (flush_kind != NO_FLUSH) begin
            flush_i = 1'b1;
            @(negedge clk);
            flush_i = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                abort_run();
            end
        end
    end

    always @(posedge clk) begin : compare_outputs
        time due;
        if (rst_n && dec_valid_o) begin
            if (exp_addr_q.size() == 0) begin
                $display("decoder output at %0t with no packet outstanding", $time);
                abort_run();
            end else begin
                due = exp_time_q.pop_front();
                check_addr(dec_addr_o, exp_addr_q.pop_front(), "dec_addr_o");
                check_mask(dec_mask_o, exp_mask_q.pop_front(), "dec_mask_o");
                check_pair(dec_insts_o, exp_pair_q.pop_front(), "dec_insts_o");
                if (due != 64'd0 && $time != due) begin
                    $display("hit at %0t did not arrive in the cycle after acceptance", $time);
                    abort_run();
                end
            end
        end
        if (rst_n && mem_req_o && mem_ack_i) begin
            req_seen++;
            if (exp_line_q.size() == 0) begin
                $display("memory request at %0t with no predicted miss", $time);
                abort_run();
            end else begin
                check_addr(mem_addr_o, exp_line_q.pop_front(), "mem_addr_o");
                // a line is eight words
                check_len(mem_len_o, icache_pkg::beat_len_t'(8), "mem_len_o");
            end
        end
    end

    initial begin
        int                      kind;
        icache_pkg::addr_t       a;
        icache_pkg::fetch_mask_t m;
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        fetch_mask_i  = '0;
        req_seen      = 0;
        req_expect    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // cold miss, then hits across the line with every mask
        send_packet(32'h0000_1008, 2'b11, NO_FLUSH);
        send_packet(32'h0000_1010, 2'b11, NO_FLUSH);
        send_packet(32'h0000_101c, 2'b11, NO_FLUSH);
        send_packet(32'h0000_1000, 2'b01, NO_FLUSH);
        send_packet(32'h0000_1018, 2'b10, NO_FLUSH);
        send_packet(32'h0000_1008, 2'b00, NO_FLUSH);
        send_packet(32'h0000_5000, 2'b00, NO_FLUSH);
        // three lines in set 0
        send_packet(32'h0000_2000, 2'b11, NO_FLUSH);
        send_packet(32'h0000_3004, 2'b11, NO_FLUSH);
        send_packet(32'h0000_2008, 2'b11, NO_FLUSH);
        send_packet(32'h0000_1000, 2'b11, NO_FLUSH);
        // flush in the stage, then during a refill, then hit the filled line
        send_packet(32'h0000_4020, 2'b11, STAGE_FLUSH);
        send_packet(32'h0000_4020, 2'b11, REFILL_FLUSH);
        send_packet(32'h0000_4038, 2'b11, NO_FLUSH);

        // four tags over four sets keep the conflicts frequent
        for (int i = 0; i < N_RAND; i++) begin
            a = u_mem.rand_bits(2) << 12;
            a = a | (u_mem.rand_bits(2) << 5);
            a = a | u_mem.rand_bits(5);
            m = icache_pkg::fetch_mask_t'(u_mem.rand_bits(2));
            kind = NO_FLUSH;
            if (u_mem.rand_bits(3) == 32'd0) begin
                kind = 1 + int'(u_mem.rand_bits(1));
            end
            send_packet(a, m, kind);
        end

        while (exp_addr_q.size() != 0 || !fetch_ready_o) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (req_seen != req_expect) begin
            $display("Fail at %0t: %0d memory requests, expected %0d", $time, req_seen,
                     req_expect);
            abort_run();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* bench/mem_model.sv */
module mem_model #(
    parameter int DLY_BITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req_i,
    input  icache_pkg::addr_t     mem_addr_i,
    input  icache_pkg::beat_len_t mem_len_i,
    output logic                  mem_ack_o,
    output logic                  mem_data_valid_o,
    output icache_pkg::inst_t     mem_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] lfsr_q = 32'hbaa1_f2f9;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0000_0000);
        end
        return r;
    endfunction

    // fixed mixing rule over the whole address
    function automatic icache_pkg::inst_t mem_word(input icache_pkg::addr_t a);
        icache_pkg::inst_t w;
        w = (a * 32'h9e37_79b1) ^ (a >> 13);
        return w ^ 32'h5a3c_c3a5;
    endfunction

    initial begin
        icache_pkg::addr_t base;
        int                len;
        int                ack_dly;
        int                gap [icache_pkg::LINE_BEATS];
        mem_ack_o        = 1'b0;
        mem_data_valid_o = 1'b0;
        mem_data_o       = '0;
        forever begin
            @(posedge clk);
            if (rst_n && mem_req_i) begin
                base = mem_addr_i;
                len  = int'(mem_len_i);
                // all delays drawn on the rising edge
                ack_dly = rand_bits(DLY_BITS);
                for (int i = 0; i < icache_pkg::LINE_BEATS; i++) begin
                    gap[i] = rand_bits(DLY_BITS);
                end
                @(negedge clk);
                repeat (ack_dly) @(negedge clk);
                mem_ack_o = 1'b1;
                @(negedge clk);
                mem_ack_o = 1'b0;
                for (int i = 0; i < len; i++) begin
                    repeat (gap[i % icache_pkg::LINE_BEATS]) @(negedge clk);
                    mem_data_valid_o = 1'b1;
                    mem_data_o       = mem_word(base + 32'(4 * i));
                    @(negedge clk);
                    mem_data_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* src/icache_top.sv */
module icache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  logic                    fetch_valid_i,
    input  icache_pkg::addr_t       fetch_addr_i,
    input  icache_pkg::fetch_mask_t fetch_mask_i,
    output logic                    fetch_ready_o,
    output logic                    dec_valid_o,
    output icache_pkg::addr_t       dec_addr_o,
    output icache_pkg::fetch_mask_t dec_mask_o,
    output icache_pkg::inst_pair_t  dec_insts_o,
    output logic                    mem_req_o,
    output icache_pkg::addr_t       mem_addr_o,
    output icache_pkg::beat_len_t   mem_len_o,
    input  logic                    mem_ack_i,
    input  logic                    mem_data_valid_i,
    input  icache_pkg::inst_t       mem_data_i
);

    logic                   lookup_en;
    icache_pkg::addr_t      lookup_index;
    icache_pkg::tag_t       cmp_tag;
    icache_pkg::way_vec_t   hit;
    icache_pkg::inst_pair_t hit_pair;

    refill_if fill_bus ();

    miss_ctrl u_miss_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_addr_i     (fetch_addr_i),
        .fetch_mask_i     (fetch_mask_i),
        .fetch_ready_o    (fetch_ready_o),
        .dec_valid_o      (dec_valid_o),
        .dec_addr_o       (dec_addr_o),
        .dec_mask_o       (dec_mask_o),
        .dec_insts_o      (dec_insts_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_len_o        (mem_len_o),
        .mem_ack_i        (mem_ack_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .lookup_en_o      (lookup_en),
        .lookup_index_o   (lookup_index),
        .cmp_tag_o        (cmp_tag),
        .hit_i            (hit),
        .hit_pair_i       (hit_pair),
        .fill             (fill_bus.ctrl)
    );

    way_arrays u_way_arrays (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_en_i    (lookup_en),
        .lookup_index_i (lookup_index),
        .cmp_tag_i      (cmp_tag),
        .hit_o          (hit),
        .hit_pair_o     (hit_pair),
        .fill           (fill_bus.arrays)
    );

endmodule

/* src/miss_ctrl.sv */
module miss_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,
    input  logic                      fetch_valid_i,
    input  icache_pkg::addr_t         fetch_addr_i,
    input  icache_pkg::fetch_mask_t   fetch_mask_i,
    output logic                      fetch_ready_o,
    output logic                      dec_valid_o,
    output icache_pkg::addr_t         dec_addr_o,
    output icache_pkg::fetch_mask_t   dec_mask_o,
    output icache_pkg::inst_pair_t    dec_insts_o,
    output logic                      mem_req_o,
    output icache_pkg::addr_t         mem_addr_o,
    output icache_pkg::beat_len_t     mem_len_o,
    input  logic                      mem_ack_i,
    input  logic                      mem_data_valid_i,
    input  icache_pkg::inst_t         mem_data_i,
    output logic                      lookup_en_o,
    output icache_pkg::addr_t         lookup_index_o,
    output icache_pkg::tag_t          cmp_tag_o,
    input  icache_pkg::way_vec_t      hit_i,
    input  icache_pkg::inst_pair_t    hit_pair_i,
    refill_if.ctrl                    fill
);

    icache_pkg::refill_state_e state_q;
    icache_pkg::refill_state_e state_d;
    logic                      stg_valid;
    icache_pkg::addr_t         stg_addr;
    icache_pkg::fetch_mask_t   stg_mask;
    icache_pkg::beat_cnt_t     beat_cnt_q;
    icache_pkg::inst_t         lo_word_q;
    icache_pkg::inst_pair_t    ret_pair_q;
    logic                      miss;
    logic                      beat;
    logic                      pair_done;

    // mask zero is a bubble and never misses
    assign miss = (state_q == icache_pkg::S_LOOKUP) && stg_valid && (|stg_mask)
                  && !(|hit_i) && !flush_i;
    assign beat      = (state_q == icache_pkg::S_MISS_FILL) && mem_data_valid_i;
    assign pair_done = beat && beat_cnt_q[0];

    assign fetch_ready_o = !flush_i && (((state_q == icache_pkg::S_LOOKUP) && !miss)
                                        || (state_q == icache_pkg::S_RETURN));
    assign lookup_en_o    = fetch_valid_i && fetch_ready_o;
    assign lookup_index_o = fetch_addr_i;
    assign cmp_tag_o      = stg_addr[31:12];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stg_valid <= 1'b0;
        end else if (flush_i) begin
            stg_valid <= 1'b0;
        end else if (fetch_ready_o) begin
            stg_valid <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en_o) begin
            stg_addr <= {fetch_addr_i[31:3], 3'b000};
            stg_mask <= fetch_mask_i;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            icache_pkg::S_LOOKUP: begin
                if (miss) begin
                    state_d = mem_ack_i ? icache_pkg::S_MISS_FILL : icache_pkg::S_MISS_REQ;
                end
            end
            icache_pkg::S_MISS_REQ: begin
                if (mem_ack_i) begin
                    state_d = icache_pkg::S_MISS_FILL;
                end
            end
            icache_pkg::S_MISS_FILL: begin
                if (pair_done && (&beat_cnt_q)) begin
                    state_d = icache_pkg::S_RETURN;
                end
            end
            icache_pkg::S_RETURN: begin
                state_d = icache_pkg::S_LOOKUP;
            end
            default: begin
                state_d = icache_pkg::S_LOOKUP;
            end
        endcase
    end

    // counter wraps back to zero after the eighth beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= icache_pkg::S_LOOKUP;
            beat_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (beat) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat && !beat_cnt_q[0]) begin
            lo_word_q <= mem_data_i;
        end
        // keep the pair the held packet asked for
        if (pair_done && (beat_cnt_q[2:1] == stg_addr[4:3])) begin
            ret_pair_q <= fill.wr_data;
        end
    end

    assign mem_req_o  = miss || (state_q == icache_pkg::S_MISS_REQ);
    assign mem_addr_o = {stg_addr[31:5], 5'b00000};
    assign mem_len_o  = icache_pkg::beat_len_t'(icache_pkg::LINE_BEATS);

    assign fill.wr_en    = pair_done;
    assign fill.wr_index = {stg_addr[11:5], beat_cnt_q[2:1]};
    assign fill.wr_data  = {mem_data_i, lo_word_q};
    assign fill.wr_tag   = stg_addr[31:12];
    assign fill.wr_last  = &beat_cnt_q;

    assign dec_valid_o = !flush_i && stg_valid && (|stg_mask)
                         && (((state_q == icache_pkg::S_LOOKUP) && (|hit_i))
                             || (state_q == icache_pkg::S_RETURN));
    assign dec_insts_o = (state_q == icache_pkg::S_RETURN) ? ret_pair_q : hit_pair_i;
    assign dec_addr_o  = stg_addr;
    assign dec_mask_o  = stg_mask;

endmodule

/* src/way_arrays.sv */
module way_arrays (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lookup_en_i,
    input  icache_pkg::addr_t      lookup_index_i,
    input  icache_pkg::tag_t       cmp_tag_i,
    output icache_pkg::way_vec_t   hit_o,
    output icache_pkg::inst_pair_t hit_pair_o,
    refill_if.arrays               fill
);

    icache_pkg::set_idx_t   rd_set;
    icache_pkg::pair_idx_t  rd_pair;
    icache_pkg::set_idx_t   set_q;
    icache_pkg::set_idx_t   fill_set;
    icache_pkg::way_vec_t   fill_way;
    icache_pkg::way_vec_t [icache_pkg::SET_NUM-1:0] valid_q;
    logic [icache_pkg::SET_NUM-1:0] victim_q;
    icache_pkg::tag_t       tag_rd [icache_pkg::WAY_NUM];
    icache_pkg::inst_pair_t pair_rd [icache_pkg::WAY_NUM];

    assign rd_set  = lookup_index_i[11:5];
    assign rd_pair = lookup_index_i[11:3];

    // set index is the top of the pair index
    assign fill_set = fill.wr_index[8:2];
    assign fill_way = icache_pkg::way_vec_t'(1) << victim_q[fill_set];

    // lines up the valid bits with the ram output
    always_ff @(posedge clk) begin
        if (lookup_en_i) begin
            set_q <= rd_set;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (fill.wr_en) begin
            valid_q[fill_set] <= valid_q[fill_set] | fill_way;
            // next refill of this set goes to the other way
            if (fill.wr_last) begin
                victim_q[fill_set] <= ~victim_q[fill_set];
            end
        end
    end

    for (genvar w = 0; w < icache_pkg::WAY_NUM; w++) begin : g_way
        sram_1r1w #(
            .WIDTH($bits(icache_pkg::tag_t)),
            .DEPTH(icache_pkg::SET_NUM)
        ) u_tag_ram (
            .clk       (clk),
            .rd_en_i   (lookup_en_i),
            .rd_addr_i (rd_set),
            .rd_data_o (tag_rd[w]),
            .wr_en_i   (fill.wr_en && fill_way[w]),
            .wr_addr_i (fill_set),
            .wr_data_i (fill.wr_tag)
        );

        sram_1r1w #(
            .WIDTH($bits(icache_pkg::inst_pair_t)),
            .DEPTH(icache_pkg::SET_NUM * icache_pkg::PAIRS_PER_LINE)
        ) u_data_ram (
            .clk       (clk),
            .rd_en_i   (lookup_en_i),
            .rd_addr_i (rd_pair),
            .rd_data_o (pair_rd[w]),
            .wr_en_i   (fill.wr_en && fill_way[w]),
            .wr_addr_i (fill.wr_index),
            .wr_data_i (fill.wr_data)
        );

        assign hit_o[w] = valid_q[set_q][w] && (tag_rd[w] == cmp_tag_i);
    end

    // at most one way hits
    always_comb begin
        hit_pair_o = '0;
        for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
            if (hit_o[w]) begin
                hit_pair_o = hit_pair_o | pair_rd[w];
            end
        end
    end

endmodule

/* src/sram_1r1w.sv */
module sram_1r1w #(
    parameter int unsigned WIDTH = 32,
    parameter int unsigned DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output logic [WIDTH-1:0]         rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  logic [WIDTH-1:0]         wr_data_i
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // same-address write wins over the old contents
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            if (wr_en_i && (wr_addr_i == rd_addr_i)) begin
                rd_data_o <= wr_data_i;
            end else begin
                rd_data_o <= mem[rd_addr_i];
            end
        end
    end

endmodule

/* src/refill_if.sv */
interface refill_if;

    logic                   wr_en;
    icache_pkg::pair_idx_t  wr_index;
    icache_pkg::inst_pair_t wr_data;
    icache_pkg::tag_t       wr_tag;
    // final pair of the line
    logic                   wr_last;

    modport ctrl (
        output wr_en,
        output wr_index,
        output wr_data,
        output wr_tag,
        output wr_last
    );

    modport arrays (
        input wr_en,
        input wr_index,
        input wr_data,
        input wr_tag,
        input wr_last
    );

endinterface

/* src/icache_pkg.sv */
package icache_pkg;

    // cache geometry
    localparam int unsigned WAY_NUM        = 2;
    localparam int unsigned SET_NUM        = 128;
    localparam int unsigned LINE_BEATS     = 8;
    localparam int unsigned PAIRS_PER_LINE = 4;

    // byte address
    typedef logic [31:0] addr_t;

    // one instruction or one memory beat
    typedef logic [31:0] inst_t;

    // lower word at the lower address
    typedef logic [63:0] inst_pair_t;

    // address bits 31..12
    typedef logic [19:0] tag_t;

    // address bits 11..5
    typedef logic [6:0] set_idx_t;

    // address bits 11..3
    typedef logic [8:0] pair_idx_t;

    // bit 0 is the lower word
    typedef logic [1:0] fetch_mask_t;

    typedef logic [1:0] way_vec_t;

    typedef logic [3:0] beat_len_t;

    typedef logic [2:0] beat_cnt_t;

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_MISS_REQ,
        S_MISS_FILL,
        S_RETURN
    } refill_state_e;

endpackage
